/* common/cache_mem_if.sv */
interface cache_mem_if import fa_cache_pkg::*; ();

	cache_addr_t addr;  // {line, word}
	logic        wr_en;
	data_t       wdata;
	data_t       rdata; // registered, valid one cycle after addr

	modport controller (
		output addr, wr_en, wdata,
		input  rdata
	);

	modport ram (
		input  addr, wr_en, wdata,
		output rdata
	);

endinterface

/* common/fa_cache_pkg.sv */
package fa_cache_pkg;

	// ------------------------------------------------------------
	// address and data geometry
	// ------------------------------------------------------------
	localparam int BW_WORD_ADDR = 16;                      // core word address
	localparam int BW_BLOCK     = 3;                       // word offset inside a block
	localparam int BLOCK_WORDS  = 8;                       // 1 << BW_BLOCK
	localparam int BW_LINE      = 3;                       // line index
	localparam int CACHE_LINES  = 8;                       // fully associative, 1 << BW_LINE
	localparam int BW_TAG       = BW_WORD_ADDR - BW_BLOCK; // 13 bits of tag
	localparam int BW_DATA      = 32;

	// ------------------------------------------------------------
	// vector types
	// ------------------------------------------------------------
	typedef logic [BW_WORD_ADDR-1:0]     word_addr_t;  // core or memory word address
	typedef logic [BW_TAG-1:0]           tag_t;
	typedef logic [BW_LINE-1:0]          line_idx_t;
	typedef logic [BW_BLOCK-1:0]         word_off_t;
	typedef logic [BW_LINE+BW_BLOCK-1:0] cache_addr_t; // {line, word} into the data ram
	typedef logic [BW_DATA-1:0]          data_t;

	// ------------------------------------------------------------
	// controller fsm
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		ST_IDLE,         // wait for core, tag lookup
		ST_LOOKUP_DONE,  // hit served, done pulse
		ST_VICTIM,       // victim latched, dirty check
		ST_WRITE_BUFFER, // old block -> write buffer
		ST_WRITE_CMD,    // block write command
		ST_FILL_CMD,     // block read command
		ST_READ_BUFFER,  // read buffer -> data ram
		ST_REPLAY        // second lookup after the fill
	} ctrl_state_t;

endpackage

/* common/tag_cam_if.sv */
interface tag_cam_if import fa_cache_pkg::*; ();

	// lookup port, combinational
	tag_t                   lookup_tag;
	logic                   hit;
	line_idx_t              hit_line;

	// write port, takes effect on the next edge
	logic                   wr_en;
	line_idx_t              wr_line;
	tag_t                   wr_tag;

	// indexed tag read, used for the writeback address
	line_idx_t              rd_line;
	tag_t                   rd_tag;

	logic [CACHE_LINES-1:0] valid; // one per line

	modport controller (
		output lookup_tag, wr_en, wr_line, wr_tag, rd_line,
		input  hit, hit_line, valid, rd_tag
	);

	modport cam (
		input  lookup_tag, wr_en, wr_line, wr_tag, rd_line,
		output hit, hit_line, valid, rd_tag
	);

endinterface

/* controller/cache_controller.sv */
module cache_controller import fa_cache_pkg::*; (
	input  logic       clock_i,
	input  logic       resetn_i,

	// core side, held by the core until done
	input  logic       core_req_i,
	input  logic       core_rw_i,            // 1 = store
	input  word_addr_t core_addr_i,
	input  data_t      core_data_i,
	output logic       core_done_o,
	output logic       core_hit_o,
	output data_t      core_data_o,

	// memory command port
	input  logic       mem_ready_i,
	output logic       mem_req_o,            // one cycle pulse, block request
	output logic       mem_rw_o,             // 1 = block write
	output word_addr_t mem_addr_o,

	// word buffers toward memory
	input  logic       buffer_read_ready_i,  // fill word at head
	input  data_t      buffer_data_i,
	output logic       buffer_read_ack_o,
	input  logic       buffer_write_ready_i, // space for a writeback word
	output data_t      buffer_data_o,
	output logic       buffer_write_ack_o,

	// tag cam and data ram
	tag_cam_if.controller  cam,
	cache_mem_if.controller ram,

	// line state tracker
	input  line_idx_t  victim_line_i,
	input  logic       victim_dirty_i,
	output logic       fill_done_o,
	output logic       store_hit_o,
	output line_idx_t  store_line_o,
	output logic       writeback_done_o
);

	// ------------------------------------------------------------
	// state and decode
	// ------------------------------------------------------------
	ctrl_state_t state_q, state_d;
	word_off_t   cnt_q, cnt_d;   // word counter for writeback and fill
	line_idx_t   victim_q;       // line being replaced
	logic        miss_q;         // current access missed on first lookup
	tag_t        core_tag;
	word_off_t   core_word;
	logic        lookup_active;

	assign core_tag  = core_addr_i[BW_WORD_ADDR-1:BW_BLOCK];
	assign core_word = core_addr_i[BW_BLOCK-1:0];

	// first lookup from idle, second one after the fill
	assign lookup_active = (state_q == ST_IDLE && core_req_i) || (state_q == ST_REPLAY);

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= ST_IDLE;
			cnt_q   <= '0;
			miss_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			if (state_q == ST_IDLE && core_req_i) begin
				miss_q <= ~cam.hit; // replay keeps the miss flag
			end
		end
	end

	// victim stays fixed until the fill is done
	always_ff @(posedge clock_i) begin
		if (lookup_active && !cam.hit) begin
			victim_q <= victim_line_i;
		end
	end

	// ------------------------------------------------------------
	// next state and strobes
	// ------------------------------------------------------------
	always_comb begin
		state_d          = state_q;
		cnt_d            = cnt_q;

		cam.lookup_tag   = core_tag;
		cam.rd_line      = victim_q;   // old tag for the writeback address
		cam.wr_en        = 1'b0;
		cam.wr_line      = victim_q;
		cam.wr_tag       = core_tag;   // new block comes from the core address

		ram.addr         = {victim_q, cnt_q};
		ram.wr_en        = 1'b0;
		ram.wdata        = core_data_i;

		mem_req_o         = 1'b0;
		buffer_read_ack_o  = 1'b0;
		buffer_write_ack_o = 1'b0;
		fill_done_o       = 1'b0;
		store_hit_o       = 1'b0;
		writeback_done_o  = 1'b0;

		case (state_q)
			ST_IDLE, ST_REPLAY: begin
				if (lookup_active) begin
					if (cam.hit) begin
						ram.addr    = {cam.hit_line, core_word};
						ram.wr_en   = core_rw_i;
						store_hit_o = core_rw_i; // marks the line dirty
						state_d     = ST_LOOKUP_DONE;
					end else begin
						state_d = ST_VICTIM;
					end
				end
			end

			ST_LOOKUP_DONE: begin
				state_d = ST_IDLE;      // rdata for the core is on the bus now
			end

			// ram address already points at word 0 of the victim
			ST_VICTIM: begin
				if (victim_dirty_i) begin
					state_d = ST_WRITE_BUFFER;
				end else begin
					state_d = ST_FILL_CMD;
				end
			end

			ST_WRITE_BUFFER: begin
				if (buffer_write_ready_i) begin
					buffer_write_ack_o = 1'b1;
					cnt_d              = cnt_q + 1'b1;
					ram.addr           = {victim_q, cnt_d}; // prefetch next word
					if (cnt_q == word_off_t'(BLOCK_WORDS - 1)) begin
						state_d = ST_WRITE_CMD;
					end
				end
			end

			// whole block is buffered before the command goes out
			ST_WRITE_CMD: begin
				if (mem_ready_i) begin
					mem_req_o        = 1'b1;
					writeback_done_o = 1'b1;
					state_d          = ST_FILL_CMD;
				end
			end

			ST_FILL_CMD: begin
				if (mem_ready_i) begin
					mem_req_o = 1'b1;
					state_d   = ST_READ_BUFFER;
				end
			end

			ST_READ_BUFFER: begin
				if (buffer_read_ready_i) begin
					buffer_read_ack_o = 1'b1;
					ram.wr_en         = 1'b1;
					ram.wdata         = buffer_data_i;
					cnt_d             = cnt_q + 1'b1;
					if (cnt_q == word_off_t'(BLOCK_WORDS - 1)) begin
						cam.wr_en   = 1'b1; // tag valid with the last word
						fill_done_o = 1'b1;
						state_d     = ST_REPLAY;
					end
				end
			end

			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------
	assign mem_rw_o   = (state_q == ST_WRITE_CMD);
	assign mem_addr_o = mem_rw_o ? {cam.rd_tag, {BW_BLOCK{1'b0}}}
	                             : {core_tag, {BW_BLOCK{1'b0}}};

	assign buffer_data_o = ram.rdata;          // streamed straight from the ram
	assign core_done_o   = (state_q == ST_LOOKUP_DONE);
	assign core_hit_o    = core_done_o & ~miss_q;
	assign core_data_o   = ram.rdata;
	assign store_line_o  = cam.hit_line;

	// ------------------------------------------------------------
	// protocol checks
	// ------------------------------------------------------------
	// write command and fill read may go out on back to back cycles
	a_req_ready: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_o |-> mem_ready_i)
		else $error("mem_req_o without mem_ready_i");

	a_read_ack: assert property (@(posedge clock_i) disable iff (!resetn_i)
		buffer_read_ack_o |-> buffer_read_ready_i)
		else $error("read buffer popped while empty");

	a_write_ack: assert property (@(posedge clock_i) disable iff (!resetn_i)
		buffer_write_ack_o |-> buffer_write_ready_i)
		else $error("write buffer pushed while full");

endmodule

/* controller/line_state_tracker.sv */
module line_state_tracker import fa_cache_pkg::*; (
	input  logic                   clock_i,
	input  logic                   resetn_i,
	input  logic [CACHE_LINES-1:0] valid_i,          // from the cam
	input  logic                   fill_done_i,      // one per completed fill
	input  logic                   store_hit_i,
	input  line_idx_t              store_line_i,
	input  logic                   writeback_done_i, // victim block handed to memory
	output line_idx_t              victim_line_o,
	output logic                   victim_dirty_o
);

	logic [CACHE_LINES-1:0] dirty_q;
	line_idx_t              rr_ptr_q; // used once every line is valid

	// lowest invalid line wins, else round robin
	always_comb begin
		victim_line_o = rr_ptr_q;
		for (int i = CACHE_LINES - 1; i >= 0; i--) begin
			if (!valid_i[i]) begin
				victim_line_o = line_idx_t'(i);
			end
		end
	end

	assign victim_dirty_o = dirty_q[victim_line_o];

	// victim does not move between writeback and fill
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			dirty_q  <= '0;
			rr_ptr_q <= '0;
		end else begin
			if (writeback_done_i) begin
				dirty_q[victim_line_o] <= 1'b0;
			end
			if (store_hit_i) begin
				dirty_q[store_line_i] <= 1'b1;
			end
			if (fill_done_i) begin
				rr_ptr_q <= rr_ptr_q + 1'b1; // wraps at CACHE_LINES
			end
		end
	end

	// stores only land on lines the cam holds
	a_dirty_valid: assert property (@(posedge clock_i) disable iff (!resetn_i)
		(dirty_q & ~valid_i) == '0)
		else $error("dirty bit set on an invalid line");

endmodule

/* files.f */
common/fa_cache_pkg.sv
common/tag_cam_if.sv
common/cache_mem_if.sv
controller/cache_controller.sv
controller/line_state_tracker.sv
verilog/tag_cam.sv
verilog/cache_data_ram.sv
verilog/fa_cache_top.sv
sim/backing_mem_model.sv
sim/fa_cache_tb.sv

/* sim/backing_mem_model.sv */
module backing_mem_model import fa_cache_pkg::*; (
	input  logic        clock_i,
	input  logic        resetn_i,
	input  logic        stall_en_i,           // random stalls on or off
	input  logic [31:0] stall_rnd_i,          // fresh random word each cycle
	output logic        mem_ready_o,
	input  logic        mem_req_i,
	input  logic        mem_rw_i,             // 1 = block write
	input  word_addr_t  mem_addr_i,
	output logic        buffer_read_ready_o,
	output data_t       buffer_read_data_o,
	input  logic        buffer_read_ack_i,
	output logic        buffer_write_ready_o,
	input  data_t       buffer_write_data_i,
	input  logic        buffer_write_ack_i
);

	localparam int BUF_DEPTH = BLOCK_WORDS; // one block per buffer

	data_t     mem_q [2**BW_WORD_ADDR];
	data_t     rbuf_q [BUF_DEPTH];
	data_t     wbuf_q [BUF_DEPTH];
	int        rd_count_q;
	word_off_t rd_head_q;
	int        wr_count_q;
	logic [2:0] stall; // {write buffer, read buffer, command}

	// known contents, every address bit matters
	function automatic data_t pattern_word(input word_addr_t addr);
		return {addr ^ 16'ha5c3, ~addr};
	endfunction

	initial begin
		for (int a = 0; a < 2**BW_WORD_ADDR; a++) begin
			mem_q[a] = pattern_word(word_addr_t'(a));
		end
	end

	// a ready drops when its two random bits are zero, about one cycle in four
	assign stall = stall_en_i ? {stall_rnd_i[31:30] == 2'b00, stall_rnd_i[29:28] == 2'b00,
		stall_rnd_i[27:26] == 2'b00} : 3'b000;

	// ------------------------------------------------------------
	// buffers and block commands
	// ------------------------------------------------------------
	always @(posedge clock_i) begin
		if (!resetn_i) begin
			rd_count_q <= 0;
			rd_head_q  <= '0;
			wr_count_q <= 0;
		end else begin
			if (buffer_write_ack_i) begin
				wbuf_q[wr_count_q] <= buffer_write_data_i;
				wr_count_q         <= wr_count_q + 1;
			end
			if (buffer_read_ack_i) begin
				rd_head_q  <= rd_head_q + 1'b1; // wraps after the last word
				rd_count_q <= rd_count_q - 1;
			end
			if (mem_req_i && mem_rw_i) begin
				for (int i = 0; i < BUF_DEPTH; i++) begin
					mem_q[word_addr_t'(mem_addr_i + i)] <= wbuf_q[i];
				end
				wr_count_q <= 0; // buffer drained into memory
			end
			if (mem_req_i && !mem_rw_i) begin
				for (int i = 0; i < BUF_DEPTH; i++) begin
					rbuf_q[i] <= mem_q[word_addr_t'(mem_addr_i + i)];
				end
				rd_head_q  <= '0;
				rd_count_q <= BUF_DEPTH;
			end
		end
	end

	// no new command while a fill is still queued
	assign mem_ready_o          = !stall[0] && (rd_count_q == 0);
	assign buffer_read_ready_o  = !stall[1] && (rd_count_q != 0);
	assign buffer_read_data_o   = rbuf_q[rd_head_q];
	assign buffer_write_ready_o = !stall[2] && (wr_count_q < BUF_DEPTH);

endmodule

/* sim/fa_cache_tb.sv */
module fa_cache_tb import fa_cache_pkg::*; ();

	localparam int          TIMEOUT_CYCLES = 2000;
	localparam logic [31:0] SEED           = 32'h26c1_ce4f;

	logic clock_i, resetn_i;
	logic core_req, core_rw, core_done, core_hit;
	word_addr_t core_addr, mem_addr;
	data_t core_data, core_rdata, rd_data, wr_data;
	logic mem_ready, mem_req, mem_rw;
	logic rd_ready, rd_ack, wr_ready, wr_ack;
	logic [31:0] stall_rnd   = '0;
	logic        stall_en    = 1'b0;
	logic [31:0] stall_state = SEED;
	logic        timed_out   = 1'b0;

	// reference state: line contents, pointer and shadow memory
	tag_t                   ref_tag [CACHE_LINES];
	logic [CACHE_LINES-1:0] ref_valid;
	line_idx_t              ref_ptr;
	data_t                  shadow [word_addr_t];

	logic [BW_DATA+1:0] expect_q [$];  // {load, hit, data}
	logic               cmd_rw_q [$];
	word_addr_t         cmd_addr_q [$];
	int errors = 0, checks = 0, failed_tests = 0, done_count = 0;

	fa_cache_top fa_cache_top_inst (
		.clock_i (clock_i), .resetn_i (resetn_i),
		.core_req_i (core_req), .core_rw_i (core_rw), .core_addr_i (core_addr),
		.core_data_i (core_data), .core_done_o (core_done), .core_hit_o (core_hit),
		.core_data_o (core_rdata), .mem_ready_i (mem_ready), .mem_req_o (mem_req),
		.mem_rw_o (mem_rw), .mem_addr_o (mem_addr), .buffer_read_ready_i (rd_ready),
		.buffer_data_i (rd_data), .buffer_read_ack_o (rd_ack),
		.buffer_write_ready_i (wr_ready), .buffer_data_o (wr_data),
		.buffer_write_ack_o (wr_ack)
	);

	backing_mem_model backing_mem_model_inst (
		.clock_i (clock_i), .resetn_i (resetn_i),
		.stall_en_i (stall_en), .stall_rnd_i (stall_rnd),
		.mem_ready_o (mem_ready), .mem_req_i (mem_req), .mem_rw_i (mem_rw),
		.mem_addr_i (mem_addr), .buffer_read_ready_o (rd_ready),
		.buffer_read_data_o (rd_data), .buffer_read_ack_i (rd_ack),
		.buffer_write_ready_o (wr_ready), .buffer_write_data_i (wr_data),
		.buffer_write_ack_i (wr_ack)
	);

	initial begin
		clock_i = 1'b0;
		forever #2 clock_i = ~clock_i;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic data_t pattern_word(input word_addr_t addr);
		return {addr ^ 16'ha5c3, ~addr}; // same fill as the memory model
	endfunction

	// returns {hit, load data}, updates the line model and shadow memory
	function automatic logic [BW_DATA:0] reference_access(input logic rw, input word_addr_t addr,
			input data_t wdata);
		logic      hit;
		line_idx_t victim;
		data_t     rdata;
		tag_t      tag;
		tag = addr[BW_WORD_ADDR-1:BW_BLOCK];
		hit = 1'b0;
		for (int i = 0; i < CACHE_LINES; i++) begin
			if (ref_valid[i] && ref_tag[i] == tag) hit = 1'b1;
		end
		if (!hit) begin
			victim = ref_ptr;                  // all valid, round robin
			for (int i = CACHE_LINES - 1; i >= 0; i--) begin
				if (!ref_valid[i]) victim = line_idx_t'(i);
			end
			ref_tag[victim]   = tag;
			ref_valid[victim] = 1'b1;
			ref_ptr           = ref_ptr + 1'b1; // every fill moves it
		end
		rdata = shadow.exists(addr) ? shadow[addr] : pattern_word(addr);
		if (rw) shadow[addr] = wdata;
		return {hit, rdata};
	endfunction

	task automatic check(input logic cond, input string msg);
		checks++;
		assert (cond) else begin
			$display("CHECK FAILED at %0t: %s", $time, msg);
			errors++;
		end
	endtask

	// one blocking core access, cycles counted from the driving edge
	task automatic run_access(input logic rw, input word_addr_t addr, input data_t wdata,
			output int cycles, output logic hit);
		logic [BW_DATA:0] ref_result;
		ref_result = reference_access(rw, addr, wdata);
		hit        = ref_result[BW_DATA];
		cycles     = 0;
		if (!timed_out) begin
			expect_q.push_back({~rw, ref_result});
			@(posedge clock_i);
			core_req  <= 1'b1;
			core_rw   <= rw;
			core_addr <= addr;
			core_data <= wdata;
			do begin
				@(posedge clock_i);
				cycles++;
			end while (!core_done && cycles < TIMEOUT_CYCLES);
			core_req <= 1'b0;
			if (!core_done) begin
				$display("ERROR at %0t: core_done_o never came for an access", $time);
				errors++;
				timed_out = 1'b1; // dut is stuck, later accesses are skipped
			end
		end
	endtask

	// one edge first so the compare process has seen the last done pulse
	task automatic report_test(input int num, input string name, input int err_start);
		@(posedge clock_i);
		if (errors == err_start) $display("test %0d %s: ok", num, name);
		else begin
			$display("test %0d %s: %0d errors", num, name, errors - err_start);
			failed_tests++;
		end
	endtask

	// ------------------------------------------------------------
	// monitors
	// ------------------------------------------------------------
	always @(posedge clock_i) begin : compare_done
		logic [BW_DATA+1:0] expected;
		if (resetn_i && core_done) begin
			done_count++;
			check(expect_q.size() > 0, "done pulse without a request");
			if (expect_q.size() > 0) begin
				expected = expect_q.pop_front();
				check(core_hit == expected[BW_DATA], $sformatf("hit flag %0b, expected %0b",
					core_hit, expected[BW_DATA]));
				check(!expected[BW_DATA+1] || core_rdata == expected[BW_DATA-1:0],
					$sformatf("load data %h, expected %h", core_rdata, expected[BW_DATA-1:0]));
			end
		end
	end

	always @(posedge clock_i) begin
		if (resetn_i && mem_req) begin
			cmd_rw_q.push_back(mem_rw);
			cmd_addr_q.push_back(mem_addr);
		end
	end

	// raw random word for the memory model stalls
	always @(posedge clock_i) begin
		stall_state = lcg_next(stall_state);
		stall_rnd  <= stall_state;
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin : stimulus
		int          cycles;
		int          err_start;
		logic        hit;
		logic [31:0] rnd;
		word_addr_t  addr;
		resetn_i  = 1'b0;
		core_req  = 1'b0;
		core_rw   = 1'b0;
		core_addr = '0;
		core_data = '0;
		ref_valid = '0;
		ref_ptr   = '0;
		rnd       = SEED;
		repeat (16) @(posedge clock_i);
		resetn_i <= 1'b1;

		err_start = errors;
		repeat (20) begin
			@(posedge clock_i);
			check(!core_done && !core_hit && !mem_req && !rd_ack && !wr_ack,
				"strobe active while idle");
		end
		report_test(1, "idle after reset", err_start);

		err_start = errors;
		cmd_rw_q.delete();
		cmd_addr_q.delete();
		run_access(1'b0, 16'h1235, '0, cycles, hit);
		check(cmd_rw_q.size() == 1 && cmd_rw_q[0] == 1'b0 && cmd_addr_q[0] == 16'h1230,
			"cold miss did not issue exactly one aligned read");
		report_test(2, "cold load miss", err_start);

		err_start = errors;
		run_access(1'b0, 16'h1232, '0, cycles, hit);
		check(hit && cycles == 2, $sformatf("hit took %0d cycles", cycles));
		report_test(3, "load hit latency", err_start);

		err_start = errors;
		cmd_rw_q.delete();
		run_access(1'b1, 16'h1236, 32'hdead_beef, cycles, hit);
		run_access(1'b0, 16'h1236, '0, cycles, hit);
		check(cmd_rw_q.size() == 0, "memory command on a store hit");
		report_test(4, "store hit then load", err_start);

		err_start = errors;
		for (int i = 1; i < CACHE_LINES; i++) begin
			run_access(1'b0, word_addr_t'(16'h1230 + i * 16'h0100), '0, cycles, hit);
		end
		cmd_rw_q.delete();
		cmd_addr_q.delete();
		run_access(1'b0, 16'h2000, '0, cycles, hit); // ninth block, dirty line 0 leaves
		check(cmd_rw_q.size() == 2 && cmd_rw_q[0] == 1'b1 && cmd_addr_q[0] == 16'h1230
			&& cmd_rw_q[1] == 1'b0 && cmd_addr_q[1] == 16'h2000,
			"writeback did not precede the fill read");
		run_access(1'b0, 16'h1236, '0, cycles, hit);
		report_test(5, "dirty eviction", err_start);

		err_start = errors;
		stall_en <= 1'b1;
		repeat (300) begin
			rnd  = lcg_next(rnd);
			addr = 16'h4000 | word_addr_t'(rnd[22:16]); // 16 blocks, twice the cache
			run_access(rnd[5], addr, lcg_next(rnd), cycles, hit);
		end
		stall_en <= 1'b0;
		report_test(6, "random traffic with stalls", err_start);

		$display("tests: 6 run, %0d failed; checks: %0d, errors: %0d, done pulses: %0d",
			failed_tests, checks, errors, done_count);
		if (errors == 0) $display("All tests passed");
		else $display("Some tests failed");
		$finish;
	end

endmodule

/* verilog/cache_data_ram.sv */
module cache_data_ram import fa_cache_pkg::*; (
	input logic      clock_i,
	cache_mem_if.ram ram
);

	// 64 words, line major
	data_t mem_q [CACHE_LINES * BLOCK_WORDS];
	data_t rdata_q;

	// ------------------------------------------------------------
	// single port, read before write
	// ------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (ram.wr_en) begin
			mem_q[ram.addr] <= ram.wdata;
		end
		rdata_q <= mem_q[ram.addr]; // old word on a write cycle
	end

	assign ram.rdata = rdata_q;

endmodule

/* verilog/fa_cache_top.sv */
module fa_cache_top import fa_cache_pkg::*; (
	input  logic       clock_i,
	input  logic       resetn_i,

	// core side
	input  logic       core_req_i,
	input  logic       core_rw_i,
	input  word_addr_t core_addr_i,
	input  data_t      core_data_i,
	output logic       core_done_o,
	output logic       core_hit_o,
	output data_t      core_data_o,

	// memory commands
	input  logic       mem_ready_i,
	output logic       mem_req_o,
	output logic       mem_rw_o,
	output word_addr_t mem_addr_o,

	// word buffers
	input  logic       buffer_read_ready_i,
	input  data_t      buffer_data_i,
	output logic       buffer_read_ack_o,
	input  logic       buffer_write_ready_i,
	output data_t      buffer_data_o,
	output logic       buffer_write_ack_o
);

	tag_cam_if   cam_bus ();
	cache_mem_if ram_bus ();

	// tracker handshake
	line_idx_t victim_line;
	logic      victim_dirty;
	logic      fill_done;
	logic      store_hit;
	line_idx_t store_line;
	logic      writeback_done;

	// ------------------------------------------------------------
	// controller and its helpers
	// ------------------------------------------------------------
	cache_controller cache_controller_inst (
		.clock_i              (clock_i),
		.resetn_i             (resetn_i),
		.core_req_i           (core_req_i),
		.core_rw_i            (core_rw_i),
		.core_addr_i          (core_addr_i),
		.core_data_i          (core_data_i),
		.core_done_o          (core_done_o),
		.core_hit_o           (core_hit_o),
		.core_data_o          (core_data_o),
		.mem_ready_i          (mem_ready_i),
		.mem_req_o            (mem_req_o),
		.mem_rw_o             (mem_rw_o),
		.mem_addr_o           (mem_addr_o),
		.buffer_read_ready_i  (buffer_read_ready_i),
		.buffer_data_i        (buffer_data_i),
		.buffer_read_ack_o    (buffer_read_ack_o),
		.buffer_write_ready_i (buffer_write_ready_i),
		.buffer_data_o        (buffer_data_o),
		.buffer_write_ack_o   (buffer_write_ack_o),
		.cam                  (cam_bus.controller),
		.ram                  (ram_bus.controller),
		.victim_line_i        (victim_line),
		.victim_dirty_i       (victim_dirty),
		.fill_done_o          (fill_done),
		.store_hit_o          (store_hit),
		.store_line_o         (store_line),
		.writeback_done_o     (writeback_done)
	);

	line_state_tracker line_state_tracker_inst (
		.clock_i          (clock_i),
		.resetn_i         (resetn_i),
		.valid_i          (cam_bus.valid),  // valid bits straight from the cam
		.fill_done_i      (fill_done),
		.store_hit_i      (store_hit),
		.store_line_i     (store_line),
		.writeback_done_i (writeback_done),
		.victim_line_o    (victim_line),
		.victim_dirty_o   (victim_dirty)
	);

	tag_cam tag_cam_inst (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.cam      (cam_bus.cam)
	);

	cache_data_ram cache_data_ram_inst (
		.clock_i (clock_i),
		.ram     (ram_bus.ram)
	);

endmodule

/* verilog/tag_cam.sv */
module tag_cam import fa_cache_pkg::*; (
	input logic    clock_i,
	input logic    resetn_i,
	tag_cam_if.cam cam
);

	// ------------------------------------------------------------
	// tag store
	// ------------------------------------------------------------
	tag_t                   tags_q [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid_q;
	logic [CACHE_LINES-1:0] match;  // per line compare result

	// a line never goes invalid again once filled
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (cam.wr_en) begin
			valid_q[cam.wr_line] <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (cam.wr_en) begin
			tags_q[cam.wr_line] <= cam.wr_tag;
		end
	end

	// ------------------------------------------------------------
	// parallel lookup
	// ------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < CACHE_LINES; i++) begin
			match[i] = valid_q[i] && (tags_q[i] == cam.lookup_tag);
		end
	end

	// encode matching line, lowest index if ever more than one
	always_comb begin
		cam.hit_line = '0;
		for (int i = CACHE_LINES - 1; i >= 0; i--) begin
			if (match[i]) begin
				cam.hit_line = line_idx_t'(i);
			end
		end
	end

	assign cam.hit    = |match;
	assign cam.valid  = valid_q;
	assign cam.rd_tag = tags_q[cam.rd_line]; // indexed read for writeback

	// controller only fills a tag after it missed
	a_single_match: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$onehot0(match))
		else $error("tag present in more than one line");

endmodule
